/* alu.sv */
`timescale 1ns/1ns

module alu (
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  logic [4:0]     shamt,
    input  mipsPkg::aluOpT op,
    output logic [31:0]    y
);
    import mipsPkg::*;

    logic [31:0] sum;
    logic [31:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////
    always_comb begin
        case (op)
            ADD: begin
                y = sum;
            end
            SUB: begin
                y = diff;
            end
            AND: begin
                y = a & b;
            end
            OR: begin
                y = a | b;
            end
            XOR: begin
                y = a ^ b;
            end
            NOR: begin
                y = ~(a | b);
            end
            SLT: begin
                y = {31'b0, $signed(a) < $signed(b)};
            end
            SLTU: begin
                y = {31'b0, a < b};
            end
            // Shifts act on the rt operand
            SLL: begin
                y = b << shamt;
            end
            SRL: begin
                y = b >> shamt;
            end
            SRA: begin
                y = $signed(b) >>> shamt;
            end
            // Immediate already placed in the upper half
            LUI: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

/* apbExecTop.sv */
`timescale 1ns/1ns
`include "mipsDefs.svh"

module apbExecTop (
    input  logic        clk,
    input  logic        rstN,
    input  logic        pSel,
    input  logic        pEnable,
    input  logic        pWrite,
    input  logic [11:0] pAddr,
    input  logic [31:0] pWData,
    output logic [31:0] pRData,
    output logic        pReady,
    output logic        pSlvErr
);
    import mipsPkg::*;

    typedef enum logic {
        IDLE,
        MD_WAIT
    } stateT;

    stateT       state;
    logic [31:0] instrQ;

    logic regWrite, regDst, aluSrc, shiftImm, shiftVar, mdStart;
    logic mfHi, mfLo, mtHi, mtLo, illegal;
    aluOpT aluOp;
    extOpT extOp;
    mdOpT  mdOp;

    logic [31:0] rsData, rtData, dbgData, wbData;
    logic [31:0] extImm, aluB, aluY, hi, lo;
    logic [4:0]  shamt, rdSel;
    logic [11:0] regOff;
    logic        busy, access, wrInstr, rdOk, inRegWin, exec, zeroDiv, mdGo;

    ////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////
    assign access   = pSel && pEnable;
    assign regOff   = pAddr - `ADDR_REG_BASE;
    assign inRegWin = (pAddr >= `ADDR_REG_BASE) && (regOff < `REG_WIN_BYTES)
                   && (regOff[1:0] == 2'b00);
    assign wrInstr  = pWrite && (pAddr == `ADDR_INSTR);
    assign rdOk     = !pWrite && (inRegWin || pAddr == `ADDR_HI || pAddr == `ADDR_LO);

    assign exec     = access && (state == IDLE) && wrInstr && !illegal;
    assign zeroDiv  = ((mdOp == DIV) || (mdOp == DIVU)) && (rtData == '0);
    assign mdGo     = exec && mdStart && !zeroDiv;

    assign pReady  = access && (((state == IDLE) && !mdGo) || ((state == MD_WAIT) && !busy));
    assign pSlvErr = access && (state == IDLE) && !(rdOk || (wrInstr && !illegal));

    always_comb begin
        pRData = '0;
        if (access && !pWrite) begin
            if (inRegWin)               pRData = dbgData;
            else if (pAddr == `ADDR_HI) pRData = hi;
            else if (pAddr == `ADDR_LO) pRData = lo;
        end
    end

    // Word is stable from the setup phase on
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= IDLE;
            instrQ <= '0;
        end else begin
            if (pSel && !pEnable) begin
                instrQ <= pWData;
            end
            if ((state == IDLE) && mdGo) begin
                state <= MD_WAIT;
            end else if ((state == MD_WAIT) && pReady) begin
                state <= IDLE;
            end
        end
    end

    ////////////////////////////////////////
    // Execute datapath
    ////////////////////////////////////////
    always_comb begin
        case (extOp)
            SIGN:    extImm = {{16{instrQ[15]}}, instrQ[15:0]};
            UPPER:   extImm = {instrQ[15:0], 16'h0000};
            default: extImm = {16'h0000, instrQ[15:0]};
        endcase
    end

    assign aluB   = aluSrc ? extImm : rtData;
    assign shamt  = shiftVar ? rsData[4:0] : (shiftImm ? instrQ[10:6] : 5'd0);
    assign rdSel  = regDst ? instrQ[15:11] : instrQ[20:16];
    assign wbData = mfHi ? hi : (mfLo ? lo : aluY);

    control uControl (
        .instr(instrQ), .regWrite(regWrite), .regDst(regDst), .aluSrc(aluSrc),
        .shiftImm(shiftImm), .shiftVar(shiftVar), .mdStart(mdStart), .mfHi(mfHi),
        .mfLo(mfLo), .mtHi(mtHi), .mtLo(mtLo), .illegal(illegal), .aluOp(aluOp),
        .extOp(extOp), .mdOp(mdOp)
    );

    alu uAlu (.a(rsData), .b(aluB), .shamt(shamt), .op(aluOp), .y(aluY));

    regFile uRegFile (
        .clk(clk), .rstN(rstN), .we(exec && regWrite), .rs(instrQ[25:21]),
        .rt(instrQ[20:16]), .rd(rdSel), .dbgSel(regOff[6:2]), .wd(wbData),
        .rsData(rsData), .rtData(rtData), .dbgData(dbgData)
    );

    mulDiv uMulDiv (
        .clk(clk), .rstN(rstN), .start(exec && mdStart), .op(mdOp), .a(rsData),
        .b(rtData), .mtHi(exec && mtHi), .mtLo(exec && mtLo), .busy(busy),
        .hi(hi), .lo(lo)
    );

    // A completing cycle follows a setup or wait cycle
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(pReady) |-> $past(pSel))
        else $error("pReady rose outside an access phase");

endmodule

/* control.sv */
`timescale 1ns/1ns

module control (
    input  logic [31:0]    instr,
    output logic           regWrite,
    output logic           regDst,
    output logic           aluSrc,
    output logic           shiftImm,
    output logic           shiftVar,
    output logic           mdStart,
    output logic           mfHi,
    output logic           mfLo,
    output logic           mtHi,
    output logic           mtLo,
    output logic           illegal,
    output mipsPkg::aluOpT aluOp,
    output mipsPkg::extOpT extOp,
    output mipsPkg::mdOpT  mdOp
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       rType;
    logic isAdd, isAddu, isSub, isSubu, isAnd, isOr, isXor, isNor;
    logic isSlt, isSltu, isSll, isSrl, isSra, isSllv, isSrlv, isSrav;
    logic isMult, isMultu, isDiv, isDivu, isMfhi, isMthi, isMflo, isMtlo;
    logic isAddi, isAddiu, isSlti, isSltiu, isAndi, isOri, isXori, isLui;
    logic immOp;
    logic supported;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rType  = (opcode == 6'b000000);

    ////////////////////////////////////////
    // One-hot instruction matches
    ////////////////////////////////////////
    assign isAdd   = rType && (funct == 6'b100000);
    assign isAddu  = rType && (funct == 6'b100001);
    assign isSub   = rType && (funct == 6'b100010);
    assign isSubu  = rType && (funct == 6'b100011);
    assign isAnd   = rType && (funct == 6'b100100);
    assign isOr    = rType && (funct == 6'b100101);
    assign isXor   = rType && (funct == 6'b100110);
    assign isNor   = rType && (funct == 6'b100111);
    assign isSlt   = rType && (funct == 6'b101010);
    assign isSltu  = rType && (funct == 6'b101011);

    assign isSll   = rType && (funct == 6'b000000);
    assign isSrl   = rType && (funct == 6'b000010);
    assign isSra   = rType && (funct == 6'b000011);
    assign isSllv  = rType && (funct == 6'b000100);
    assign isSrlv  = rType && (funct == 6'b000110);
    assign isSrav  = rType && (funct == 6'b000111);

    assign isMfhi  = rType && (funct == 6'b010000);
    assign isMthi  = rType && (funct == 6'b010001);
    assign isMflo  = rType && (funct == 6'b010010);
    assign isMtlo  = rType && (funct == 6'b010011);
    assign isMult  = rType && (funct == 6'b011000);
    assign isMultu = rType && (funct == 6'b011001);
    assign isDiv   = rType && (funct == 6'b011010);
    assign isDivu  = rType && (funct == 6'b011011);

    assign isAddi  = (opcode == 6'b001000);
    assign isAddiu = (opcode == 6'b001001);
    assign isSlti  = (opcode == 6'b001010);
    assign isSltiu = (opcode == 6'b001011);
    assign isAndi  = (opcode == 6'b001100);
    assign isOri   = (opcode == 6'b001101);
    assign isXori  = (opcode == 6'b001110);
    assign isLui   = (opcode == 6'b001111);

    // Every word in the supported set
    assign supported = isAdd | isAddu | isSub | isSubu | isAnd | isOr | isXor | isNor
                     | isSlt | isSltu | isSll | isSrl | isSra | isSllv | isSrlv | isSrav
                     | isMult | isMultu | isDiv | isDivu | isMfhi | isMthi | isMflo | isMtlo
                     | isAddi | isAddiu | isSlti | isSltiu | isAndi | isOri | isXori | isLui;

    ////////////////////////////////////////
    // Control lines
    ////////////////////////////////////////
    assign immOp    = isAddi | isAddiu | isSlti | isSltiu | isAndi | isOri | isXori | isLui;
    assign shiftImm = isSll | isSrl | isSra;
    assign shiftVar = isSllv | isSrlv | isSrav;
    assign regDst   = isAdd | isAddu | isSub | isSubu | isAnd | isOr | isXor | isNor
                    | isSlt | isSltu | shiftImm | shiftVar | isMfhi | isMflo;
    assign regWrite = regDst | immOp;
    assign aluSrc   = immOp;
    assign mdStart  = isMult | isMultu | isDiv | isDivu;
    assign mfHi     = isMfhi;
    assign mfLo     = isMflo;
    assign mtHi     = isMthi;
    assign mtLo     = isMtlo;
    assign illegal  = !supported;

    always_comb begin
        aluOp = ADD;
        if (isSub | isSubu)        aluOp = SUB;
        else if (isAnd | isAndi)   aluOp = AND;
        else if (isOr | isOri)     aluOp = OR;
        else if (isXor | isXori)   aluOp = XOR;
        else if (isNor)            aluOp = NOR;
        else if (isSlt | isSlti)   aluOp = SLT;
        else if (isSltu | isSltiu) aluOp = SLTU;
        else if (isSll | isSllv)   aluOp = SLL;
        else if (isSrl | isSrlv)   aluOp = SRL;
        else if (isSra | isSrav)   aluOp = SRA;
        else if (isLui)            aluOp = LUI;
    end

    // sltiu compares against the sign-extended immediate
    always_comb begin
        extOp = ZERO;
        if (isAddi | isAddiu | isSlti | isSltiu) extOp = SIGN;
        else if (isLui)                          extOp = UPPER;
    end

    always_comb begin
        mdOp = MULT;
        if (isMultu)     mdOp = MULTU;
        else if (isDiv)  mdOp = DIV;
        else if (isDivu) mdOp = DIVU;
    end

    always_comb begin
        assert (!(illegal && (regWrite || mdStart)))
            else $error("Unsupported word raised a write or a multiply/divide start");
    end

endmodule

/* mipsDefs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// APB address map
`define ADDR_INSTR      12'h000
`define ADDR_REG_BASE   12'h100
`define REG_WIN_BYTES   12'h080
`define ADDR_HI         12'h200
`define ADDR_LO         12'h204

// Iterations per multiply or divide
`define MD_STEPS        32

`endif

/* mipsPkg.sv */
package mipsPkg;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI
    } aluOpT;

    ////////////////////////////////////////
    // Immediate extension
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        ZERO,
        SIGN,
        UPPER
    } extOpT;

    ////////////////////////////////////////
    // Multiply and divide
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        MULT,
        MULTU,
        DIV,
        DIVU
    } mdOpT;

endpackage

/* mulDiv.sv */
`timescale 1ns/1ns
`include "mipsDefs.svh"

module mulDiv (
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  mipsPkg::mdOpT op,
    input  logic [31:0]   a,
    input  logic [31:0]   b,
    input  logic          mtHi,
    input  logic          mtLo,
    output logic          busy,
    output logic [31:0]   hi,
    output logic [31:0]   lo
);
    import mipsPkg::*;

    localparam int CntW = $clog2(`MD_STEPS);

    logic            isSigned;
    logic            isDivOp;
    logic            accept;
    logic [31:0]     aMag;
    logic [31:0]     bMag;

    logic [CntW-1:0] stepCnt;
    logic [63:0]     acc;
    logic [31:0]     opB;
    logic            divMode;
    logic            negHi;
    logic            negLo;

    logic [32:0]     sumHi;
    logic [32:0]     remShl;
    logic [33:0]     trial;
    logic [63:0]     accNext;
    logic [63:0]     prodFix;
    logic [31:0]     hiRes;
    logic [31:0]     loRes;

    assign isSigned = (op == MULT) || (op == DIV);
    assign isDivOp  = (op == DIV) || (op == DIVU);
    assign accept   = start && !(isDivOp && (b == '0));
    assign aMag     = (isSigned && a[31]) ? -a : a;
    assign bMag     = (isSigned && b[31]) ? -b : b;

    ////////////////////////////////////////
    // One iteration step
    ////////////////////////////////////////
    assign sumHi  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opB} : 33'd0);
    assign remShl = acc[63:31];
    assign trial  = {1'b0, remShl} - {2'b00, opB};

    always_comb begin
        if (divMode) begin
            // Restore when the trial subtraction goes negative
            accNext = trial[33] ? {remShl[31:0], acc[30:0], 1'b0}
                                : {trial[31:0], acc[30:0], 1'b1};
        end else begin
            accNext = {sumHi, acc[31:1]};
        end
    end

    // Sign fix on magnitudes, quotient toward zero
    assign prodFix = negLo ? -accNext : accNext;

    always_comb begin
        if (divMode) begin
            hiRes = negHi ? -accNext[63:32] : accNext[63:32];
            loRes = negLo ? -accNext[31:0] : accNext[31:0];
        end else begin
            hiRes = prodFix[63:32];
            loRes = prodFix[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc     <= {32'b0, aMag};
            opB     <= bMag;
            divMode <= isDivOp;
            negLo   <= isSigned && (a[31] ^ b[31]);
            negHi   <= isSigned && a[31];
        end else if (busy) begin
            acc <= accNext;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy    <= 1'b0;
            stepCnt <= '0;
            hi      <= '0;
            lo      <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            stepCnt <= '0;
        end else if (busy) begin
            stepCnt <= stepCnt + 1'b1;
            if (stepCnt == CntW'(`MD_STEPS - 1)) begin
                busy <= 1'b0;
                hi   <= hiRes;
                lo   <= loRes;
            end
        end else begin
            if (mtHi) begin
                hi <= a;
            end
            if (mtLo) begin
                lo <= a;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
        else $error("Multiply/divide start while busy");

endmodule

/* regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic [4:0]  rd,
    input  logic [4:0]  dbgSel,
    input  logic [31:0] wd,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    output logic [31:0] dbgData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            // Register zero stays at zero
            regs[rd] <= wd;
        end
    end

    assign rsData  = regs[rs];
    assign rtData  = regs[rt];
    assign dbgData = regs[dbgSel];

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timescale 1ns/1ns --top-module tbApbExec \
    -f sources.f -o simApbExec > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simApbExec > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Test failures found" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$SIM_LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* sources.f */
+incdir+.
mipsPkg.sv
control.sv
alu.sv
mulDiv.sv
regFile.sv
apbExecTop.sv
tbApbExec.sv

/* tbApbExec.sv */
`timescale 1ns/1ns
`include "mipsDefs.svh"

module tbApbExec;

    localparam int TimeoutCycles = 100;

    logic        clk;
    logic        rstN;
    logic        pSel;
    logic        pEnable;
    logic        pWrite;
    logic [11:0] pAddr;
    logic [31:0] pWData;
    logic [31:0] pRData;
    logic        pReady;
    logic        pSlvErr;

    logic [31:0] rngState;
    logic [31:0] modelRegs [32];
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    int          errors;
    int          checks;

    apbExecTop DUT (
        .clk(clk), .rstN(rstN), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
        .pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady),
        .pSlvErr(pSlvErr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    task automatic modelStep(input logic [31:0] w, output logic legal, output logic hasDest,
                             output logic [4:0] destReg, output logic hiLo, output int waits);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [4:0]  sa;
        longint      sa64;
        longint      sb64;
        longint      q64;
        longint      r64;
        logic [63:0] p64;
        a = modelRegs[w[25:21]];
        b = modelRegs[w[20:16]];
        sa = w[10:6];
        sImm = {{16{w[15]}}, w[15:0]};
        zImm = {16'h0000, w[15:0]};
        sa64 = longint'($signed(a));
        sb64 = longint'($signed(b));
        legal = 1'b1;
        hasDest = 1'b1;
        hiLo = 1'b0;
        waits = 0;
        res = '0;
        destReg = (w[31:26] == 6'h00) ? w[15:11] : w[20:16];
        if (w[31:26] == 6'h00) begin
            case (w[5:0])
                6'h20, 6'h21: res = a + b;
                6'h22, 6'h23: res = a - b;
                6'h24: res = a & b;
                6'h25: res = a | b;
                6'h26: res = a ^ b;
                6'h27: res = ~(a | b);
                6'h2a: res = {31'b0, $signed(a) < $signed(b)};
                6'h2b: res = {31'b0, a < b};
                6'h00: res = b << sa;
                6'h02: res = b >> sa;
                6'h03: res = $signed(b) >>> sa;
                6'h04: res = b << a[4:0];
                6'h06: res = b >> a[4:0];
                6'h07: res = $signed(b) >>> a[4:0];
                6'h10: res = modelHi;
                6'h12: res = modelLo;
                6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b: hasDest = 1'b0;
                default: begin
                    legal = 1'b0;
                    hasDest = 1'b0;
                end
            endcase
            hiLo = !hasDest && legal;
            if (w[5:0] == 6'h11) modelHi = a;
            if (w[5:0] == 6'h13) modelLo = a;
            if (w[5:0] == 6'h18 || w[5:0] == 6'h19) begin
                p64 = (w[5:0] == 6'h18) ? sa64 * sb64 : {32'h0, a} * {32'h0, b};
                modelHi = p64[63:32];
                modelLo = p64[31:0];
                waits = `MD_STEPS + 1;
            end
            // Zero divisor leaves HI and LO alone and adds no wait states
            if ((w[5:0] == 6'h1a || w[5:0] == 6'h1b) && b != '0) begin
                if (w[5:0] == 6'h1a) begin
                    q64 = sa64 / sb64;
                    r64 = sa64 % sb64;
                    modelLo = q64[31:0];
                    modelHi = r64[31:0];
                end else begin
                    modelLo = a / b;
                    modelHi = a % b;
                end
                waits = `MD_STEPS + 1;
            end
        end else begin
            case (w[31:26])
                6'h08, 6'h09: res = a + sImm;
                6'h0a: res = {31'b0, $signed(a) < $signed(sImm)};
                6'h0b: res = {31'b0, a < sImm};
                6'h0c: res = a & zImm;
                6'h0d: res = a | zImm;
                6'h0e: res = a ^ zImm;
                6'h0f: res = {w[15:0], 16'h0000};
                default: begin
                    legal = 1'b0;
                    hasDest = 1'b0;
                end
            endcase
        end
        if (hasDest && destReg != 5'd0) modelRegs[destReg] = res;
    endtask

    ////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////
    task automatic apbXfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err, output int waits);
        @(negedge clk);
        pSel = 1'b1;
        pEnable = 1'b0;
        pWrite = write;
        pAddr = addr;
        pWData = wdata;
        @(negedge clk);
        pEnable = 1'b1;
        waits = 0;
        #1;
        while (!pReady && waits < TimeoutCycles) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!pReady) begin
            $display("Timeout at %0t: pReady stayed low for %0d cycles, address %h",
                     $time, waits, addr);
            errors++;
            $display("Summary: %0d checks, %0d errors", checks, errors);
            $display("Test failures found");
            $finish;
        end else begin
            rdata = pRData;
            err = pSlvErr;
            @(negedge clk);
            pSel = 1'b0;
            pEnable = 1'b0;
        end
    endtask

    task automatic expectEqual(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic readAndCheck(input logic [11:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        logic        err;
        int          waits;
        apbXfer(1'b0, addr, 32'h0, data, err, waits);
        if (err) begin
            $display("CHECK FAILED at %0t: %s read ended with pSlvErr", $time, what);
            errors++;
        end
        expectEqual(what, data, exp);
    endtask

    task automatic checkReg(input logic [4:0] idx);
        readAndCheck(`ADDR_REG_BASE + 12'({idx, 2'b00}), modelRegs[idx],
                     $sformatf("register %0d", idx));
    endtask

    task automatic checkHiLo();
        readAndCheck(`ADDR_HI, modelHi, "HI");
        readAndCheck(`ADDR_LO, modelLo, "LO");
    endtask

    task automatic checkAllState();
        for (int k = 0; k < 32; k++) begin
            checkReg(5'(k));
        end
        checkHiLo();
    endtask

    task automatic execWord(input logic [31:0] w);
        logic        legal;
        logic        hasDest;
        logic        hiLo;
        logic [4:0]  destReg;
        int          expWaits;
        logic [31:0] data;
        logic        err;
        int          waits;
        modelStep(w, legal, hasDest, destReg, hiLo, expWaits);
        apbXfer(1'b1, `ADDR_INSTR, w, data, err, waits);
        checks++;
        if (err !== !legal) begin
            $display("CHECK FAILED at %0t: word %h gave pSlvErr %0b", $time, w, err);
            errors++;
        end
        if (waits != expWaits) begin
            $display("CHECK FAILED at %0t: word %h took %0d wait states, expected %0d",
                     $time, w, waits, expWaits);
            errors++;
        end
        if (hasDest) checkReg(destReg);
        if (hiLo) checkHiLo();
        if (!legal) checkAllState();
    endtask

    task automatic badAccess(input logic write, input logic [11:0] addr);
        logic [31:0] data;
        logic        err;
        int          waits;
        apbXfer(write, addr, nextRand(), data, err, waits);
        checks++;
        if (!err) begin
            $display("CHECK FAILED at %0t: access to %h ended without pSlvErr", $time, addr);
            errors++;
        end
        if (!write) expectEqual($sformatf("unmapped %h", addr), data, 32'h0);
    endtask

    // Field pickers
    function automatic logic [5:0] aluFunct(input logic [3:0] k);
        case (k)
            4'd0: return 6'h20;
            4'd1: return 6'h21;
            4'd2: return 6'h22;
            4'd3: return 6'h23;
            4'd4: return 6'h24;
            4'd5: return 6'h25;
            4'd6: return 6'h26;
            4'd7: return 6'h27;
            4'd8: return 6'h2a;
            default: return 6'h2b;
        endcase
    endfunction

    function automatic logic [5:0] shiftFunct(input logic [2:0] k);
        case (k)
            3'd0: return 6'h00;
            3'd1: return 6'h02;
            3'd2: return 6'h03;
            3'd3: return 6'h04;
            3'd4: return 6'h06;
            default: return 6'h07;
        endcase
    endfunction

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rt;
        rngState = 32'hcccb12b1;
        errors = 0;
        checks = 0;
        rstN = 1'b0;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = '0;
        pWData = '0;
        for (int k = 0; k < 32; k++) begin
            modelRegs[k] = '0;
        end
        modelHi = '0;
        modelLo = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        //////////////////////////////////////////
        // Reset state and register zero
        //////////////////////////////////////////
        checkAllState();
        execWord({6'h09, 5'd0, 5'd0, 16'h1234});
        execWord({6'h0f, 5'd0, 5'd0, 16'hbeef});

        // Load every register through lui and ori
        for (int k = 1; k < 32; k++) begin
            r = nextRand();
            execWord({6'h0f, 5'd0, 5'(k), r[31:16]});
            execWord({6'h0d, 5'(k), 5'(k), r[15:0]});
        end

        // Selector bits come from the upper half of the LCG state
        for (int n = 0; n < 200; n++) begin
            r = nextRand();
            s = nextRand();
            if (s[31]) execWord({6'h00, r[25:11], 5'd0, aluFunct(s[30:27])});
            else execWord({3'b001, s[26:24], r[25:0]});
        end

        //////////////////////////////////////////
        // Shifts
        //////////////////////////////////////////
        for (int n = 0; n < 100; n++) begin
            r = nextRand();
            s = nextRand();
            execWord({6'h00, r[25:6], shiftFunct(s[31:29])});
        end

        //////////////////////////////////////////
        // Multiply and divide
        //////////////////////////////////////////
        for (int n = 0; n < 60; n++) begin
            r = nextRand();
            s = nextRand();
            rt = (s[31:29] == 3'd0) ? 5'd0 : r[20:16];
            execWord({6'h00, r[25:21], rt, 10'h000, 4'b0110, s[28:27]});
        end
        // Divides by register zero
        execWord({6'h00, 5'd1, 5'd0, 10'h000, 6'h1a});
        execWord({6'h00, 5'd2, 5'd0, 10'h000, 6'h1b});
        for (int n = 0; n < 10; n++) begin
            r = nextRand();
            execWord({6'h00, r[25:21], 15'h0000, 6'h11});
            execWord({6'h00, r[20:16], 15'h0000, 6'h13});
            execWord({6'h00, 10'h000, r[15:11], 5'd0, 6'h10});
            execWord({6'h00, 10'h000, r[10:6], 5'd0, 6'h12});
        end

        //////////////////////////////////////////
        // Unsupported words and unmapped accesses
        //////////////////////////////////////////
        r = nextRand();
        execWord({6'h04, r[25:0]});
        execWord({6'h02, r[25:0]});
        execWord({6'h23, r[25:0]});
        execWord({6'h2b, r[25:0]});
        execWord({6'h00, r[25:6], 6'h08});
        execWord({6'h00, r[25:6], 6'h0c});
        badAccess(1'b1, 12'h104);
        badAccess(1'b1, `ADDR_HI);
        badAccess(1'b1, 12'h004);
        badAccess(1'b1, 12'hffc);
        badAccess(1'b0, `ADDR_INSTR);
        badAccess(1'b0, 12'h180);
        badAccess(1'b0, 12'h102);
        badAccess(1'b0, 12'h208);
        badAccess(1'b0, 12'hffc);
        checkAllState();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
